// ==== control_encoder.sv ====
module control_encoder (
	input  ctrl_pkg::ctrl_state_t     state,
	input  ctrl_pkg::operand_fields_t fields,
	output ctrl_pkg::ctrl_word_t      ctrl
);

	always_comb
	begin
		ctrl = ctrl_pkg::CTRL_IDLE;
		case (state)
			ctrl_pkg::fetch:
			begin
				// read ir from memory at pc, write back pc + 1
				ctrl.load = ctrl_pkg::LOAD_IR;
				ctrl.rw = ctrl_pkg::MEM_READ;
				ctrl.op_sel = ctrl_pkg::ALU_ADD;
				ctrl.mux.mux_B_sel = 2'b10;
				ctrl.mux.mux_pc_sel = 2'b01;
				ctrl.mux.mux_alu_sel = 2'b10;
				ctrl.mux.mux_reg_sel = 2'b11;
				ctrl.mux.mux_pcw_sel = 2'b01;
				ctrl.we.wir = 1'b1;
				ctrl.we.wa = 1'b1;
				ctrl.we.wb = 1'b1;
				ctrl.we.regw = 1'b1;
			end
			ctrl_pkg::decode:
			begin
				ctrl.load = ctrl_pkg::LOAD_IR;
				ctrl.we.wa = fields.ra_live;
				ctrl.we.wb = fields.rb_live;
			end
			ctrl_pkg::alu_exec:
			begin
				ctrl.op_sel = fields.alu_op;
				ctrl.mux.mux_a_sel = 2'b01;
				ctrl.we.wccr = fields.ccr_en;
				ctrl.we.walu = 1'b1;
			end
			ctrl_pkg::reg_write:
			begin
				ctrl.we.regw = 1'b1;
			end
			ctrl_pkg::adi_exec:
			begin
				// ra plus sign-extended immediate
				ctrl.op_sel = ctrl_pkg::ALU_ADD;
				ctrl.mux.mux_alu_sel = 2'b11;
				ctrl.mux.mux_reg_sel = 2'b11;
				ctrl.we.wccr = 1'b1;
				ctrl.we.walu = 1'b1;
				ctrl.we.wa = 1'b1;
			end
			ctrl_pkg::adi_write:
			begin
				ctrl.mux.mux_pcw_sel = 2'b11;
				ctrl.mux.mux_adi_sel = 1'b1;
				ctrl.we.regw = 1'b1;
			end
			ctrl_pkg::mem_addr:
			begin
				// effective address into the alu register
				ctrl.op_sel = ctrl_pkg::ALU_ADD;
				ctrl.mux.mux_pc_sel = 2'b10;
				ctrl.mux.mux_alu_sel = 2'b11;
				ctrl.we.walu = 1'b1;
				ctrl.we.wa = 1'b1;
			end
			ctrl_pkg::load_write:
			begin
				ctrl.rw = ctrl_pkg::MEM_READ;
				ctrl.mux.mux_mem_sel = 1'b1;
				ctrl.mux.mux_reg_sel = 2'b01;
				ctrl.mux.mux_pcw_sel = 2'b11;
				ctrl.mux.mux_ccr_sel = 1'b1;
				ctrl.we.wmdr = 1'b1;
				ctrl.we.wccr = 1'b1;
				ctrl.we.regw = 1'b1;
			end
			ctrl_pkg::store_write:
			begin
				ctrl.rw = ctrl_pkg::MEM_WRITE;
				ctrl.mux.mux_mem_sel = 1'b1;
				ctrl.mux.mux_reg_sel = 2'b01;
				ctrl.mux.mux_pcw_sel = 2'b11;
				ctrl.we.aorb = 1'b1;
			end
			ctrl_pkg::beq_compare:
			begin
				ctrl.op_sel = ctrl_pkg::ALU_CMP;
				ctrl.mux.mux_mem_sel = 1'b1;
				ctrl.mux.mux_reg_sel = 2'b01;
				ctrl.mux.mux_pcw_sel = 2'b11;
				ctrl.we.walu = 1'b1;
				ctrl.we.wa = 1'b1;
				ctrl.we.wb = 1'b1;
			end
			ctrl_pkg::beq_take:
			begin
				// pc plus offset
				ctrl.op_sel = ctrl_pkg::ALU_ADD;
				ctrl.mux.mux_pc_sel = 2'b01;
				ctrl.mux.mux_alu_sel = 2'b11;
				ctrl.mux.mux_reg_sel = 2'b11;
				ctrl.mux.mux_pcw_sel = 2'b01;
				ctrl.we.regw = 1'b1;
			end
			ctrl_pkg::jump_link:
			begin
				// return address into ra
				ctrl.mux.mux_pc_sel = 2'b01;
				ctrl.mux.mux_mem_sel = 1'b1;
				ctrl.mux.mux_reg_sel = 2'b11;
				ctrl.mux.mux_pcw_sel = 2'b11;
				ctrl.we.wa = 1'b1;
				ctrl.we.regw = 1'b1;
				ctrl.we.aorb = 1'b1;
			end
			ctrl_pkg::jlr_write:
			begin
				ctrl.mux.mux_mem_sel = 1'b1;
				ctrl.mux.mux_reg_sel = 2'b11;
				ctrl.mux.mux_pcw_sel = 2'b01;
				ctrl.we.wb = 1'b1;
				ctrl.we.regw = 1'b1;
			end
			ctrl_pkg::jal_write:
			begin
				ctrl.op_sel = ctrl_pkg::ALU_ADD;
				ctrl.mux.mux_pc_sel = 2'b01;
				ctrl.mux.mux_alu_sel = 2'b01;
				ctrl.mux.mux_reg_sel = 2'b11;
				ctrl.mux.mux_pcw_sel = 2'b01;
				ctrl.we.regw = 1'b1;
			end
			ctrl_pkg::lhi_write:
			begin
				ctrl.mux.mux_mem_sel = 1'b1;
				ctrl.mux.mux_reg_sel = 2'b10;
				ctrl.mux.mux_pcw_sel = 2'b11;
				ctrl.we.regw = 1'b1;
			end
			// reset_st and any stray encoding pulse the datapath reset
			default:
			begin
				ctrl.dp_reset = 1'b1;
			end
		endcase
	end

endmodule

// ==== controller_checker.sv ====
module controller_checker (
	input  logic                 clk,
	input  logic                 reset_pin,
	input  ctrl_pkg::ctrl_word_t ctrl
);

	// failed assertions, read by the testbench at the end of the run
	int failures = 0;

	// reset_st follows any cycle with reset_pin high
	reset_gives_dp_reset: assert property (
		@(posedge clk) reset_pin |=> ctrl.dp_reset
	)
	else
	begin
		failures++;
		$error("dp_reset did not follow reset_pin");
	end

	// fetch always moves on to decode
	wir_single_cycle: assert property (
		@(posedge clk) disable iff (reset_pin) ctrl.we.wir |=> !ctrl.we.wir
	)
	else
	begin
		failures++;
		$error("wir was high in two consecutive cycles");
	end

	no_store_with_regw: assert property (
		@(posedge clk) !((ctrl.rw == ctrl_pkg::MEM_WRITE) && ctrl.we.regw)
	)
	else
	begin
		failures++;
		$error("memory write and regw were high in the same cycle");
	end

endmodule

bind multicycle_controller controller_checker u_checker (
	.clk       (clk),
	.reset_pin (reset_pin),
	.ctrl      (ctrl)
);

// ==== ctrl_pkg.sv ====
package ctrl_pkg;

	// fsm state encoding
	typedef enum logic [4:0] {
		fetch       = 5'd0,
		decode      = 5'd1,
		alu_exec    = 5'd2,
		reg_write   = 5'd3,
		adi_exec    = 5'd4,
		adi_write   = 5'd5,
		mem_addr    = 5'd6,
		load_write  = 5'd7,
		store_write = 5'd8,
		beq_compare = 5'd9,
		beq_take    = 5'd10,
		jump_link   = 5'd11,
		jlr_write   = 5'd12,
		lhi_write   = 5'd13,
		jal_write   = 5'd14,
		reset_st    = 5'd21
	} ctrl_state_t;

	// instruction word as held in the instruction register
	typedef struct packed {
		logic [3:0] opcode;
		logic [2:0] ra;
		logic [2:0] rb;
		logic [2:0] rc;
		logic       spare;
		logic [1:0] cond;
	} instr_t;

	localparam logic [3:0] OP_ADD  = 4'b0000;
	localparam logic [3:0] OP_ADI  = 4'b0001;
	localparam logic [3:0] OP_NAND = 4'b0010;
	localparam logic [3:0] OP_LHI  = 4'b0011;
	localparam logic [3:0] OP_LW   = 4'b0100;
	localparam logic [3:0] OP_SW   = 4'b0101;
	localparam logic [3:0] OP_BEQ  = 4'b1100;
	localparam logic [3:0] OP_JAL  = 4'b1000;
	localparam logic [3:0] OP_JLR  = 4'b1001;

	// cz is {carry, zero}
	localparam logic [1:0] COND_ALWAYS   = 2'b00;
	localparam logic [1:0] COND_IF_CARRY = 2'b01;
	localparam logic [1:0] COND_IF_ZERO  = 2'b10;

	localparam logic [2:0] NO_REG = 3'd7;

	localparam logic [1:0] MEM_NONE  = 2'b00;
	localparam logic [1:0] MEM_WRITE = 2'b01;
	localparam logic [1:0] MEM_READ  = 2'b10;

	// alu operation codes driven on op_sel
	localparam logic [1:0] ALU_ADD  = 2'b00;
	localparam logic [1:0] ALU_CMP  = 2'b01;
	localparam logic [1:0] ALU_NONE = 2'b11;

	// datapath load codes
	localparam logic [1:0] LOAD_IR   = 2'b01;
	localparam logic [1:0] LOAD_IDLE = 2'b11;

	typedef struct packed {
		logic [1:0] mux_B_sel;
		logic [1:0] mux_pc_sel;
		logic       mux_mem_sel;
		logic [1:0] mux_alu_sel;
		logic [1:0] mux_reg_sel;
		logic [1:0] mux_pcw_sel;
		logic [1:0] mux_a_sel;
		logic       mux_adi_sel;
		logic       mux_ccr_sel;
	} mux_sel_t;

	typedef struct packed {
		logic wa;
		logic wb;
		logic wmdr;
		logic wccr;
		logic walu;
		logic wir;
		logic regw;
		logic aorb;
	} write_en_t;

	typedef struct packed {
		mux_sel_t   mux;
		write_en_t  we;
		logic [1:0] op_sel;
		logic [1:0] rw;
		logic [1:0] load;
		logic       dp_reset;
	} ctrl_word_t;

	typedef struct packed {
		logic [1:0] alu_op;
		logic       ccr_en;
		logic       ra_live;
		logic       rb_live;
	} operand_fields_t;

	// everything off, alu idle
	localparam ctrl_word_t CTRL_IDLE = '{
		mux:      '0,
		we:       '0,
		op_sel:   ALU_NONE,
		rw:       MEM_NONE,
		load:     LOAD_IDLE,
		dp_reset: 1'b0
	};

endpackage

// ==== list.f ====
ctrl_pkg.sv
state_sequencer.sv
operand_decoder.sv
control_encoder.sv
multicycle_controller.sv
controller_checker.sv
tb_controller.sv

// ==== multicycle_controller.sv ====
module multicycle_controller (
	input  logic                 clk,
	input  logic                 reset_pin,
	input  ctrl_pkg::instr_t     instr,
	input  logic [1:0]           cz,
	input  logic                 equal,
	output ctrl_pkg::ctrl_word_t ctrl
);

	ctrl_pkg::ctrl_state_t     state;
	ctrl_pkg::operand_fields_t fields;

	// branch decisions live here
	state_sequencer u_sequencer (
		.clk       (clk),
		.reset_pin (reset_pin),
		.instr     (instr),
		.cz        (cz),
		.equal     (equal),
		.state     (state)
	);

	operand_decoder u_decoder (
		.instr  (instr),
		.fields (fields)
	);

	// moore outputs plus the decoded fields
	control_encoder u_encoder (
		.state  (state),
		.fields (fields),
		.ctrl   (ctrl)
	);

endmodule

// ==== operand_decoder.sv ====
module operand_decoder (
	input  ctrl_pkg::instr_t          instr,
	output ctrl_pkg::operand_fields_t fields
);

	logic add_type;

	// add and adi update carry/zero, nand does not
	assign add_type = (instr.opcode == ctrl_pkg::OP_ADD) || (instr.opcode == ctrl_pkg::OP_ADI);

	always_comb
	begin
		// low opcode bits select add or nand directly
		fields.alu_op = instr.opcode[1:0];
		fields.ccr_en = add_type;

		// r7 in a field means nothing to read
		fields.ra_live = (instr.ra != ctrl_pkg::NO_REG);
		fields.rb_live = (instr.rb != ctrl_pkg::NO_REG);
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_controller \
	-f list.f -o sim_controller
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_controller +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
	exit 0
fi
exit 1

// ==== state_sequencer.sv ====
module state_sequencer (
	input  logic                 clk,
	input  logic                 reset_pin,
	input  ctrl_pkg::instr_t     instr,
	input  logic [1:0]           cz,
	input  logic                 equal,
	output ctrl_pkg::ctrl_state_t state
);

	ctrl_pkg::ctrl_state_t next_state;
	logic cond_ok;

	// add/nand condition field checked against the flags
	always_comb
	begin
		case (instr.cond)
			ctrl_pkg::COND_ALWAYS:   cond_ok = 1'b1;
			ctrl_pkg::COND_IF_CARRY: cond_ok = cz[1];
			ctrl_pkg::COND_IF_ZERO:  cond_ok = cz[0];
			default:                 cond_ok = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset_pin)
		begin
			state <= ctrl_pkg::reset_st;
		end
		else
		begin
			state <= next_state;
		end
	end

	always_comb
	begin
		next_state = ctrl_pkg::fetch;
		case (state)
			ctrl_pkg::fetch:
			begin
				next_state = ctrl_pkg::decode;
			end
			ctrl_pkg::decode:
			begin
				case (instr.opcode)
					ctrl_pkg::OP_ADD, ctrl_pkg::OP_NAND:
						next_state = cond_ok ? ctrl_pkg::alu_exec : ctrl_pkg::fetch;
					ctrl_pkg::OP_ADI:
						next_state = ctrl_pkg::adi_exec;
					ctrl_pkg::OP_LW, ctrl_pkg::OP_SW:
						next_state = ctrl_pkg::mem_addr;
					ctrl_pkg::OP_LHI:
						next_state = ctrl_pkg::lhi_write;
					ctrl_pkg::OP_BEQ:
						next_state = ctrl_pkg::beq_compare;
					ctrl_pkg::OP_JAL, ctrl_pkg::OP_JLR:
						next_state = ctrl_pkg::jump_link;
					// unknown opcodes go straight back to fetch
					default:
						next_state = ctrl_pkg::fetch;
				endcase
			end
			ctrl_pkg::alu_exec:
			begin
				next_state = ctrl_pkg::reg_write;
			end
			ctrl_pkg::adi_exec:
			begin
				next_state = ctrl_pkg::adi_write;
			end
			ctrl_pkg::mem_addr:
			begin
				// sw has the low opcode bit set
				next_state = instr.opcode[0] ? ctrl_pkg::store_write : ctrl_pkg::load_write;
			end
			ctrl_pkg::beq_compare:
			begin
				next_state = equal ? ctrl_pkg::beq_take : ctrl_pkg::fetch;
			end
			ctrl_pkg::jump_link:
			begin
				if (instr.opcode == ctrl_pkg::OP_JLR)
					next_state = ctrl_pkg::jlr_write;
				else
					next_state = ctrl_pkg::jal_write;
			end
			// last steps and reset_st all return to fetch
			default:
			begin
				next_state = ctrl_pkg::fetch;
			end
		endcase
	end

endmodule

// ==== tb_controller.sv ====
module tb_controller;

	typedef struct packed {
		ctrl_pkg::instr_t instr;
		logic [1:0]       cz;
		logic             equal;
		logic [3:0]       cycles;
		// walu, regw, wccr, wmdr, memory write seen after fetch
		logic [4:0]       strobes;
		logic [1:0]       last_rw;
		// wa, wb in decode
		logic [1:0]       decode_we;
		// op_sel in the first step with walu
		logic [1:0]       alu_op;
	} row_t;

	localparam int MAX_STEPS = 8;
	localparam int RESET_CYCLES = 3;

	logic                 clk;
	logic                 reset_pin;
	ctrl_pkg::instr_t     instr;
	logic [1:0]           cz;
	logic                 equal;
	ctrl_pkg::ctrl_word_t ctrl;

	row_t        rows[$];
	logic [31:0] lfsr;
	int          mismatch_count;
	int          other_count;
	int          assert_count;
	int          cycle_count;
	int          cycle_limit;
	int          total_cycles;

	multicycle_controller DUT (
		.clk       (clk),
		.reset_pin (reset_pin),
		.instr     (instr),
		.cz        (cz),
		.equal     (equal),
		.ctrl      (ctrl)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit)
		begin
			$display("timeout: the run went past %0d cycles", cycle_limit);
			$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
			$display("Done: errors found");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	// one lfsr step per bit taken
	task automatic random_bits(input int count, output logic [3:0] bits);
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			bits = {bits[2:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, got, expected);
			mismatch_count++;
		end
	endtask

	task automatic add_row(input logic [3:0] opcode, input logic [2:0] ra,
		input logic [2:0] rb, input logic [1:0] cond, input logic [1:0] row_cz,
		input logic row_equal, input logic [3:0] cycles, input logic [4:0] strobes,
		input logic [1:0] last_rw, input logic [1:0] decode_we,
		input logic [1:0] alu_op);
		row_t r;
		r.instr = '{opcode: opcode, ra: ra, rb: rb, rc: 3'd0, spare: 1'b0, cond: cond};
		r.cz = row_cz;
		r.equal = row_equal;
		r.cycles = cycles;
		r.strobes = strobes;
		r.last_rw = last_rw;
		r.decode_we = decode_we;
		r.alu_op = alu_op;
		rows.push_back(r);
	endtask

	// starts in fetch, ends at the negedge of the next fetch
	task automatic apply_row(input int idx);
		row_t                 r;
		ctrl_pkg::ctrl_word_t w;
		ctrl_pkg::ctrl_word_t last;
		logic [3:0]           bits;
		logic [4:0]           seen;
		logic [1:0]           walu_op;
		logic                 back;
		int                   steps;
		r = rows[idx];
		random_bits(4, bits);
		r.instr.rc = bits[3:1];
		r.instr.spare = bits[0];
		instr = r.instr;
		cz = r.cz;
		equal = r.equal;
		steps = 1;
		seen = '0;
		walu_op = ctrl_pkg::ALU_NONE;
		last = ctrl;
		back = 1'b0;
		while (!back && steps <= MAX_STEPS)
		begin
			@(negedge clk);
			w = ctrl;
			if (w.we.wir)
				back = 1'b1;
			else
			begin
				if (steps == 1)
				begin
					// r7 in a field is not read
					check_value($sformatf("row%0d.decode.wa", idx), 32'(w.we.wa),
						32'(r.decode_we[1]));
					check_value($sformatf("row%0d.decode.wb", idx), 32'(w.we.wb),
						32'(r.decode_we[0]));
				end
				if (w.we.walu && !seen[4])
					walu_op = w.op_sel;
				seen = seen | {w.we.walu, w.we.regw, w.we.wccr, w.we.wmdr,
					w.rw == ctrl_pkg::MEM_WRITE};
				last = w;
				steps++;
			end
		end
		if (!back)
		begin
			$display("row %0d never returned to fetch within %0d cycles", idx, MAX_STEPS);
			other_count++;
		end
		else
		begin
			check_value($sformatf("row%0d.cycles", idx), 32'(steps), 32'(r.cycles));
			check_value($sformatf("row%0d.walu", idx), 32'(seen[4]), 32'(r.strobes[4]));
			check_value($sformatf("row%0d.regw", idx), 32'(seen[3]), 32'(r.strobes[3]));
			check_value($sformatf("row%0d.wccr", idx), 32'(seen[2]), 32'(r.strobes[2]));
			check_value($sformatf("row%0d.wmdr", idx), 32'(seen[1]), 32'(r.strobes[1]));
			check_value($sformatf("row%0d.mem_write", idx), 32'(seen[0]), 32'(r.strobes[0]));
			check_value($sformatf("row%0d.last_rw", idx), 32'(last.rw), 32'(r.last_rw));
			check_value($sformatf("row%0d.op_sel", idx), 32'(walu_op), 32'(r.alu_op));
		end
	endtask

	initial
	begin
		clk = 1'b0;
		reset_pin = 1'b1;
		instr = '0;
		cz = 2'b00;
		equal = 1'b0;
		lfsr = 32'h3961;
		mismatch_count = 0;
		other_count = 0;
		assert_count = 0;
		cycle_count = 0;
		cycle_limit = 0;
		total_cycles = 0;

		// cz is {carry, zero}; strobes are walu, regw, wccr, wmdr, memory write
		// then decode {wa, wb} and the op_sel that goes with the first walu
		add_row(ctrl_pkg::OP_ADD, 3'd1, 3'd2, ctrl_pkg::COND_ALWAYS, 2'b00, 1'b0,
			4'd4, 5'b11100, ctrl_pkg::MEM_NONE, 2'b11, ctrl_pkg::ALU_ADD);
		add_row(ctrl_pkg::OP_ADD, 3'd7, 3'd3, ctrl_pkg::COND_IF_CARRY, 2'b10, 1'b0,
			4'd4, 5'b11100, ctrl_pkg::MEM_NONE, 2'b01, ctrl_pkg::ALU_ADD);
		add_row(ctrl_pkg::OP_ADD, 3'd4, 3'd5, ctrl_pkg::COND_IF_CARRY, 2'b01, 1'b0,
			4'd2, 5'b00000, ctrl_pkg::MEM_NONE, 2'b11, ctrl_pkg::ALU_NONE);
		add_row(ctrl_pkg::OP_ADD, 3'd2, 3'd7, ctrl_pkg::COND_IF_ZERO, 2'b01, 1'b0,
			4'd4, 5'b11100, ctrl_pkg::MEM_NONE, 2'b10, ctrl_pkg::ALU_ADD);
		add_row(ctrl_pkg::OP_ADD, 3'd3, 3'd1, ctrl_pkg::COND_IF_ZERO, 2'b10, 1'b0,
			4'd2, 5'b00000, ctrl_pkg::MEM_NONE, 2'b11, ctrl_pkg::ALU_NONE);
		add_row(ctrl_pkg::OP_NAND, 3'd5, 3'd6, ctrl_pkg::COND_ALWAYS, 2'b11, 1'b0,
			4'd4, 5'b11000, ctrl_pkg::MEM_NONE, 2'b11, 2'b10);
		add_row(ctrl_pkg::OP_NAND, 3'd6, 3'd2, ctrl_pkg::COND_IF_CARRY, 2'b00, 1'b0,
			4'd2, 5'b00000, ctrl_pkg::MEM_NONE, 2'b11, ctrl_pkg::ALU_NONE);
		add_row(ctrl_pkg::OP_ADI, 3'd1, 3'd4, 2'b11, 2'b00, 1'b0,
			4'd4, 5'b11100, ctrl_pkg::MEM_NONE, 2'b11, ctrl_pkg::ALU_ADD);
		add_row(ctrl_pkg::OP_LW, 3'd2, 3'd3, 2'b01, 2'b00, 1'b0,
			4'd4, 5'b11110, ctrl_pkg::MEM_READ, 2'b11, ctrl_pkg::ALU_ADD);
		add_row(ctrl_pkg::OP_SW, 3'd4, 3'd5, 2'b10, 2'b00, 1'b0,
			4'd4, 5'b10001, ctrl_pkg::MEM_WRITE, 2'b11, ctrl_pkg::ALU_ADD);
		add_row(ctrl_pkg::OP_LHI, 3'd3, 3'd7, 2'b00, 2'b00, 1'b0,
			4'd3, 5'b01000, ctrl_pkg::MEM_NONE, 2'b10, ctrl_pkg::ALU_NONE);
		add_row(ctrl_pkg::OP_BEQ, 3'd1, 3'd2, 2'b00, 2'b00, 1'b1,
			4'd4, 5'b11000, ctrl_pkg::MEM_NONE, 2'b11, ctrl_pkg::ALU_CMP);
		add_row(ctrl_pkg::OP_BEQ, 3'd3, 3'd4, 2'b00, 2'b00, 1'b0,
			4'd3, 5'b10000, ctrl_pkg::MEM_NONE, 2'b11, ctrl_pkg::ALU_CMP);
		add_row(ctrl_pkg::OP_JAL, 3'd5, 3'd0, 2'b00, 2'b00, 1'b0,
			4'd4, 5'b01000, ctrl_pkg::MEM_NONE, 2'b11, ctrl_pkg::ALU_NONE);
		add_row(ctrl_pkg::OP_JLR, 3'd6, 3'd7, 2'b00, 2'b00, 1'b0,
			4'd4, 5'b01000, ctrl_pkg::MEM_NONE, 2'b10, ctrl_pkg::ALU_NONE);
		add_row(4'b1111, 3'd7, 3'd7, 2'b00, 2'b00, 1'b0,
			4'd2, 5'b00000, ctrl_pkg::MEM_NONE, 2'b00, ctrl_pkg::ALU_NONE);

		foreach (rows[i])
			total_cycles += int'(rows[i].cycles);
		cycle_limit = RESET_CYCLES + 2 + total_cycles + 50;

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset_pin = 1'b0;
		// still in reset_st here
		check_value("dp_reset", 32'(ctrl.dp_reset), 32'd1);
		check_value("we", 32'(ctrl.we), 32'd0);
		check_value("load", 32'(ctrl.load), 32'(ctrl_pkg::LOAD_IDLE));
		@(negedge clk);
		check_value("wir", 32'(ctrl.we.wir), 32'd1);

		foreach (rows[i])
			apply_row(i);

		assert_count = DUT.u_checker.failures;
		$display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatch_count, other_count, assert_count);
		if (mismatch_count == 0 && other_count == 0 && assert_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule
